/* qpu_pkg.sv */
package qpu_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////
  localparam int XLEN        = 32;
  localparam int NUM_REGS    = 8;
  localparam int REG_IDX_W   = 3;
  localparam int QUBIT_NUM   = 8;
  localparam int QUBIT_IDX_W = 3;
  localparam int TIME_WIDTH  = 24;
  localparam int GATE_W      = 8;

  // Opcodes, anything else runs as NOP
  typedef enum logic [5:0] {
    OP_NOP     = 6'd0,
    OP_ADDI    = 6'd1,
    OP_QWAIT   = 6'd2,
    OP_SMIS    = 6'd3,
    OP_QOP     = 6'd4,
    OP_MEASURE = 6'd5,
    OP_FMR     = 6'd6
  } qpu_op_e;

  //////////////////////////////////////////////////
  // Instruction word
  //////////////////////////////////////////////////
  // Classical format, used by ADDI, QWAIT and FMR
  typedef struct packed {
    logic [5:0]              opcode;
    logic [REG_IDX_W-1:0]    rd;
    logic [REG_IDX_W-1:0]    rs1;
    logic [3:0]              rsvd;
    logic signed [15:0]      imm;
  } qpu_cls_fmt_t;

  // Quantum format, used by SMIS, QOP and MEASURE
  typedef struct packed {
    logic [5:0]              opcode;
    logic [REG_IDX_W-1:0]    sidx;
    logic [QUBIT_NUM-1:0]    mask;
    logic [GATE_W-1:0]       gate;
    logic [6:0]              rsvd;
  } qpu_q_fmt_t;

  typedef union packed {
    qpu_cls_fmt_t cls;
    qpu_q_fmt_t   q;
  } qpu_instr_u;

  //////////////////////////////////////////////////
  // Internal and outside buses
  //////////////////////////////////////////////////
  typedef struct packed {
    qpu_op_e                 op;
    logic [REG_IDX_W-1:0]    rd;
    logic [REG_IDX_W-1:0]    rs1;
    logic [XLEN-1:0]         imm;
    logic [REG_IDX_W-1:0]    sidx;
    logic [QUBIT_NUM-1:0]    mask;
    logic [GATE_W-1:0]       gate;
    logic [QUBIT_IDX_W-1:0]  fmr_qubit;
  } qpu_dec_t;

  typedef struct packed {
    logic                    valid;
    logic [QUBIT_IDX_W-1:0]  qubit;
    logic                    value;
  } qpu_meas_t;

  typedef struct packed {
    logic                    valid;
    logic [TIME_WIDTH-1:0]   time_stamp;
    logic [GATE_W-1:0]       gate;
    logic [QUBIT_NUM-1:0]    mask;
    logic                    measure;
  } qpu_event_t;

  typedef struct packed {
    logic                    en;
    logic [REG_IDX_W-1:0]    idx;
    logic [XLEN-1:0]         cdata;
    logic [QUBIT_NUM-1:0]    mdata;
  } qpu_wb_t;

endpackage

/* qpu_exu_decode.sv */
module qpu_exu_decode (
  input  qpu_pkg::qpu_instr_u                  i_instr,
  output qpu_pkg::qpu_dec_t                    o_dec,
  output logic [qpu_pkg::REG_IDX_W-1:0]        o_rs1_idx,
  output logic [qpu_pkg::REG_IDX_W-1:0]        o_sidx
);

  logic [5:0]        opcode;
  qpu_pkg::qpu_dec_t dec;

  // Both views keep the opcode in the same top bits
  assign opcode = i_instr.cls.opcode;

  always_comb
  begin
    dec    = '0;
    dec.op = qpu_pkg::OP_NOP;
    case (opcode)
      qpu_pkg::OP_ADDI,
      qpu_pkg::OP_QWAIT:
      begin
        dec.op  = (opcode == qpu_pkg::OP_ADDI) ? qpu_pkg::OP_ADDI : qpu_pkg::OP_QWAIT;
        dec.rd  = i_instr.cls.rd;
        dec.rs1 = i_instr.cls.rs1;
        // Sign extend to full word
        dec.imm = {{(qpu_pkg::XLEN-16){i_instr.cls.imm[15]}}, i_instr.cls.imm};
      end
      qpu_pkg::OP_FMR:
      begin
        dec.op        = qpu_pkg::OP_FMR;
        dec.rd        = i_instr.cls.rd;
        dec.fmr_qubit = i_instr.cls.imm[qpu_pkg::QUBIT_IDX_W-1:0];
      end
      qpu_pkg::OP_SMIS:
      begin
        dec.op   = qpu_pkg::OP_SMIS;
        dec.sidx = i_instr.q.sidx;
        dec.mask = i_instr.q.mask;
      end
      qpu_pkg::OP_QOP,
      qpu_pkg::OP_MEASURE:
      begin
        dec.op   = (opcode == qpu_pkg::OP_QOP) ? qpu_pkg::OP_QOP : qpu_pkg::OP_MEASURE;
        dec.sidx = i_instr.q.sidx;
        dec.gate = i_instr.q.gate;
      end
      default:
      begin
        // Unknown opcode, left as NOP
        dec.op = qpu_pkg::OP_NOP;
      end
    endcase
  end

  assign o_dec     = dec;
  assign o_rs1_idx = dec.rs1;
  assign o_sidx    = dec.sidx;

endmodule

/* qpu_exu_regfile.sv */
module qpu_exu_regfile (
  input  logic                                 clk,
  input  logic                                 i_rst_n,
  input  logic [qpu_pkg::REG_IDX_W-1:0]        i_rs1_idx,
  input  logic [qpu_pkg::REG_IDX_W-1:0]        i_sidx,
  input  logic [qpu_pkg::QUBIT_IDX_W-1:0]      i_fmr_qubit,
  input  qpu_pkg::qpu_wb_t                     i_cwb,
  input  qpu_pkg::qpu_wb_t                     i_mwb,
  input  logic                                 i_time_adv,
  input  logic [qpu_pkg::TIME_WIDTH-1:0]       i_time_amt,
  input  qpu_pkg::qpu_meas_t                   i_meas,
  output logic [qpu_pkg::XLEN-1:0]             o_rs1,
  output logic [qpu_pkg::QUBIT_NUM-1:0]        o_mask,
  output logic [qpu_pkg::TIME_WIDTH-1:0]       o_time,
  output logic                                 o_mrf_bit
);

  logic [qpu_pkg::XLEN-1:0]      crf [qpu_pkg::NUM_REGS];
  logic [qpu_pkg::QUBIT_NUM-1:0] msk [qpu_pkg::NUM_REGS];
  logic [qpu_pkg::TIME_WIDTH-1:0] timeline;
  logic [qpu_pkg::QUBIT_NUM-1:0] mrf;

  //////////////////////////////////////////////////
  // Classical registers
  //////////////////////////////////////////////////
  // r0 is cleared at reset and never written
  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
    begin
      for (int i = 0; i < qpu_pkg::NUM_REGS; i++)
      begin
        crf[i] <= '0;
      end
    end
    else if (i_cwb.en && (i_cwb.idx != '0))
    begin
      crf[i_cwb.idx] <= i_cwb.cdata;
    end
  end

  // Mask registers
  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
    begin
      for (int i = 0; i < qpu_pkg::NUM_REGS; i++)
      begin
        msk[i] <= '0;
      end
    end
    else if (i_mwb.en)
    begin
      msk[i_mwb.idx] <= i_mwb.mdata;
    end
  end

  //////////////////////////////////////////////////
  // Timeline and measurement results
  //////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
    begin
      timeline <= '0;
    end
    else if (i_time_adv)
    begin
      timeline <= timeline + i_time_amt;   // wraps at TIME_WIDTH
    end
  end

  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
    begin
      mrf <= '0;
    end
    else if (i_meas.valid)
    begin
      mrf[i_meas.qubit] <= i_meas.value;
    end
  end

  // Combinational reads
  assign o_rs1     = crf[i_rs1_idx];
  assign o_mask    = msk[i_sidx];
  assign o_time    = timeline;
  assign o_mrf_bit = mrf[i_fmr_qubit];

endmodule

/* qpu_exu_moitf.sv */
module qpu_exu_moitf (
  input  logic                                 clk,
  input  logic                                 i_rst_n,
  input  logic                                 i_issue,
  input  logic [qpu_pkg::QUBIT_NUM-1:0]        i_issue_mask,
  input  qpu_pkg::qpu_meas_t                   i_meas,
  output logic [qpu_pkg::QUBIT_NUM-1:0]        o_pending
);

  logic [qpu_pkg::QUBIT_NUM-1:0] pending;
  logic [qpu_pkg::QUBIT_NUM-1:0] set_vec;
  logic [qpu_pkg::QUBIT_NUM-1:0] clr_vec;

  // One flag per qubit, results name their qubit
  assign set_vec = i_issue ? i_issue_mask : '0;
  assign clr_vec = i_meas.valid ? (qpu_pkg::QUBIT_NUM'(1) << i_meas.qubit) : '0;

  // Set wins over clear on the same bit
  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
    begin
      pending <= '0;
    end
    else
    begin
      pending <= (pending & ~clr_vec) | set_vec;
    end
  end

  assign o_pending = pending;

endmodule

/* qpu_exu_alu.sv */
module qpu_exu_alu (
  input  logic                                 clk,
  input  logic                                 i_rst_n,
  input  logic                                 i_valid,
  output logic                                 o_ready,
  input  qpu_pkg::qpu_dec_t                    i_dec,
  input  logic [qpu_pkg::XLEN-1:0]             i_rs1,
  input  logic [qpu_pkg::QUBIT_NUM-1:0]        i_mask,
  input  logic [qpu_pkg::TIME_WIDTH-1:0]       i_time,
  input  logic                                 i_mrf_bit,
  input  logic [qpu_pkg::QUBIT_NUM-1:0]        i_pending,
  output qpu_pkg::qpu_wb_t                     o_cwb,
  output qpu_pkg::qpu_wb_t                     o_mwb,
  output logic                                 o_time_adv,
  output logic [qpu_pkg::TIME_WIDTH-1:0]       o_time_amt,
  output logic                                 o_issue,
  output logic [qpu_pkg::QUBIT_NUM-1:0]        o_issue_mask,
  output qpu_pkg::qpu_event_t                  o_event
);

  logic                     is_addi;
  logic                     is_qwait;
  logic                     is_smis;
  logic                     is_qop;
  logic                     is_meas;
  logic                     is_fmr;
  logic                     stall;
  logic                     accept;
  logic                     fire;
  logic [qpu_pkg::XLEN-1:0] sum;
  qpu_pkg::qpu_event_t      evt;

  assign is_addi  = (i_dec.op == qpu_pkg::OP_ADDI);
  assign is_qwait = (i_dec.op == qpu_pkg::OP_QWAIT);
  assign is_smis  = (i_dec.op == qpu_pkg::OP_SMIS);
  assign is_qop   = (i_dec.op == qpu_pkg::OP_QOP);
  assign is_meas  = (i_dec.op == qpu_pkg::OP_MEASURE);
  assign is_fmr   = (i_dec.op == qpu_pkg::OP_FMR);

  //////////////////////////////////////////////////
  // Dispatch stall rule
  //////////////////////////////////////////////////
  // FMR waits for its qubit, MEASURE for any overlap
  assign stall   = (is_fmr && i_pending[i_dec.fmr_qubit])
                || (is_meas && |(i_mask & i_pending));
  assign o_ready = !stall;
  assign accept  = i_valid && o_ready;

  //////////////////////////////////////////////////
  // Execution and writeback requests
  //////////////////////////////////////////////////
  // Shared adder for ADDI and QWAIT
  assign sum = i_rs1 + i_dec.imm;

  always_comb
  begin
    o_cwb       = '0;
    o_cwb.en    = accept && (is_addi || is_fmr);
    o_cwb.idx   = i_dec.rd;
    o_cwb.cdata = is_fmr ? {{(qpu_pkg::XLEN-1){1'b0}}, i_mrf_bit} : sum;
  end

  always_comb
  begin
    o_mwb       = '0;
    o_mwb.en    = accept && is_smis;
    o_mwb.idx   = i_dec.sidx;
    o_mwb.mdata = i_dec.mask;
  end

  assign o_time_adv   = accept && is_qwait;
  assign o_time_amt   = sum[qpu_pkg::TIME_WIDTH-1:0];
  assign o_issue      = accept && is_meas;
  assign o_issue_mask = i_mask;

  //////////////////////////////////////////////////
  // Event output register
  //////////////////////////////////////////////////
  assign fire = accept && (is_qop || is_meas);

  // Time is the timeline before this edge
  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
    begin
      evt.valid <= 1'b0;
    end
    else
    begin
      evt.valid <= fire;
      if (fire)
      begin
        evt.time_stamp <= i_time;
        evt.gate       <= i_dec.gate;
        evt.mask       <= i_mask;
        evt.measure    <= is_meas;
      end
    end
  end

  assign o_event = evt;

endmodule

/* qpu_exu_top.sv */
module qpu_exu_top (
  input  logic                                 clk,
  input  logic                                 i_rst_n,
  input  logic                                 i_instr_valid,
  output logic                                 o_instr_ready,
  input  qpu_pkg::qpu_instr_u                  i_instr,
  input  qpu_pkg::qpu_meas_t                   i_meas,
  output qpu_pkg::qpu_event_t                  o_event
);

  qpu_pkg::qpu_dec_t                   dec;
  logic [qpu_pkg::REG_IDX_W-1:0]       rs1_idx;
  logic [qpu_pkg::REG_IDX_W-1:0]       sidx;
  logic [qpu_pkg::XLEN-1:0]            rs1_data;
  logic [qpu_pkg::QUBIT_NUM-1:0]       mask_data;
  logic [qpu_pkg::TIME_WIDTH-1:0]      time_data;
  logic                                mrf_bit;
  logic [qpu_pkg::QUBIT_NUM-1:0]       pending;
  qpu_pkg::qpu_wb_t                    cwb;
  qpu_pkg::qpu_wb_t                    mwb;
  logic                                time_adv;
  logic [qpu_pkg::TIME_WIDTH-1:0]      time_amt;
  logic                                issue;
  logic [qpu_pkg::QUBIT_NUM-1:0]       issue_mask;

  qpu_exu_decode u_decode (
    .i_instr   (i_instr ),
    .o_dec     (dec     ),
    .o_rs1_idx (rs1_idx ),
    .o_sidx    (sidx    )
  );

  qpu_exu_regfile u_regfile (
    .clk         (clk          ),
    .i_rst_n     (i_rst_n      ),
    .i_rs1_idx   (rs1_idx      ),
    .i_sidx      (sidx         ),
    .i_fmr_qubit (dec.fmr_qubit),
    .i_cwb       (cwb          ),
    .i_mwb       (mwb          ),
    .i_time_adv  (time_adv     ),
    .i_time_amt  (time_amt     ),
    .i_meas      (i_meas       ),
    .o_rs1       (rs1_data     ),
    .o_mask      (mask_data    ),
    .o_time      (time_data    ),
    .o_mrf_bit   (mrf_bit      )
  );

  // Pending measurement tracker
  qpu_exu_moitf u_moitf (
    .clk          (clk        ),
    .i_rst_n      (i_rst_n    ),
    .i_issue      (issue      ),
    .i_issue_mask (issue_mask ),
    .i_meas       (i_meas     ),
    .o_pending    (pending    )
  );

  qpu_exu_alu u_alu (
    .clk          (clk           ),
    .i_rst_n      (i_rst_n       ),
    .i_valid      (i_instr_valid ),
    .o_ready      (o_instr_ready ),
    .i_dec        (dec           ),
    .i_rs1        (rs1_data      ),
    .i_mask       (mask_data     ),
    .i_time       (time_data     ),
    .i_mrf_bit    (mrf_bit       ),
    .i_pending    (pending       ),
    .o_cwb        (cwb           ),
    .o_mwb        (mwb           ),
    .o_time_adv   (time_adv      ),
    .o_time_amt   (time_amt      ),
    .o_issue      (issue         ),
    .o_issue_mask (issue_mask    ),
    .o_event      (o_event       )
  );

endmodule

/* tb_qpu_exu_top.sv */
module tb_qpu_exu_top;

  localparam int WAIT_LIMIT = 50;

  logic                 clk;
  logic                 i_rst_n;
  logic                 i_instr_valid;
  logic                 o_instr_ready;
  qpu_pkg::qpu_instr_u  i_instr;
  qpu_pkg::qpu_meas_t   i_meas;
  qpu_pkg::qpu_event_t  o_event;

  // Reference model state
  logic [31:0] m_crf [8];
  logic [7:0]  m_msk [8];
  logic [23:0] m_time;
  logic [7:0]  m_pend;
  logic [7:0]  m_res;
  logic [7:0]  pend_n;
  logic        exp_ready;
  logic        exp_valid;
  logic [23:0] exp_time;
  logic [7:0]  exp_gate;
  logic [7:0]  exp_mask;
  logic        exp_meas;
  logic        ev_valid;
  logic [23:0] ev_time;
  logic [7:0]  ev_gate;
  logic [7:0]  ev_mask;
  logic        ev_meas;
  int          err_count;
  int          test_count;
  event        abort_ev;

  qpu_exu_top DUT (
    .clk           (clk          ),
    .i_rst_n       (i_rst_n      ),
    .i_instr_valid (i_instr_valid),
    .o_instr_ready (o_instr_ready),
    .i_instr       (i_instr      ),
    .i_meas        (i_meas       ),
    .o_event       (o_event      )
  );

  always #5 clk = ~clk;

  assign ev_valid = o_event.valid;
  assign ev_time  = o_event.time_stamp;
  assign ev_gate  = o_event.gate;
  assign ev_mask  = o_event.mask;
  assign ev_meas  = o_event.measure;

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////
  // Stall rule on the word currently offered
  always_comb
  begin
    exp_ready = 1'b1;
    if (i_instr.cls.opcode == qpu_pkg::OP_FMR && m_pend[i_instr.cls.imm[2:0]])
    begin
      exp_ready = 1'b0;
    end
    if (i_instr.cls.opcode == qpu_pkg::OP_MEASURE && |(m_msk[i_instr.q.sidx] & m_pend))
    begin
      exp_ready = 1'b0;
    end
  end

  always @(posedge clk)
  begin
    if (!i_rst_n)
    begin
      for (int i = 0; i < 8; i++)
      begin
        m_crf[i] <= '0;
        m_msk[i] <= '0;
      end
      m_time    <= '0;
      m_pend    <= '0;
      m_res     <= '0;
      exp_valid <= 1'b0;
    end
    else
    begin
      pend_n = m_pend;
      if (i_meas.valid)
      begin
        pend_n[i_meas.qubit] = 1'b0;
        m_res[i_meas.qubit] <= i_meas.value;
      end
      exp_valid <= 1'b0;
      if (i_instr_valid && exp_ready)
      begin
        case (i_instr.cls.opcode)
          qpu_pkg::OP_ADDI:
          begin
            if (i_instr.cls.rd != 3'd0)
            begin
              m_crf[i_instr.cls.rd] <= m_crf[i_instr.cls.rs1]
                + {{16{i_instr.cls.imm[15]}}, i_instr.cls.imm};
            end
          end
          qpu_pkg::OP_QWAIT:
          begin
            // Amount truncated to the timeline width, sum wraps
            m_time <= m_time + 24'(m_crf[i_instr.cls.rs1]
              + {{16{i_instr.cls.imm[15]}}, i_instr.cls.imm});
          end
          qpu_pkg::OP_SMIS:
          begin
            m_msk[i_instr.q.sidx] <= i_instr.q.mask;
          end
          qpu_pkg::OP_QOP,
          qpu_pkg::OP_MEASURE:
          begin
            exp_valid <= 1'b1;
            exp_time  <= m_time;
            exp_gate  <= i_instr.q.gate;
            exp_mask  <= m_msk[i_instr.q.sidx];
            exp_meas  <= (i_instr.cls.opcode == qpu_pkg::OP_MEASURE);
            if (i_instr.cls.opcode == qpu_pkg::OP_MEASURE)
            begin
              pend_n = pend_n | m_msk[i_instr.q.sidx];
            end
          end
          qpu_pkg::OP_FMR:
          begin
            if (i_instr.cls.rd != 3'd0)
            begin
              m_crf[i_instr.cls.rd] <= {31'b0, m_res[i_instr.cls.imm[2:0]]};
            end
          end
          default:
          begin
          end
        endcase
      end
      m_pend <= pend_n;
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////
  assert property (@(posedge clk) disable iff (!i_rst_n) o_instr_ready == exp_ready)
    else begin
      err_count++;
      $display("ERR t=%0t o_instr_ready exp=%0b got=%0b", $time,
               $sampled(exp_ready), $sampled(o_instr_ready));
    end

  assert property (@(posedge clk) disable iff (!i_rst_n) ev_valid == exp_valid)
    else begin
      err_count++;
      $display("ERR t=%0t o_event.valid exp=%0b got=%0b", $time,
               $sampled(exp_valid), $sampled(ev_valid));
    end

  assert property (@(posedge clk) disable iff (!i_rst_n) exp_valid |-> ev_time == exp_time)
    else begin
      err_count++;
      $display("ERR t=%0t o_event.time_stamp exp=%h got=%h", $time,
               $sampled(exp_time), $sampled(ev_time));
    end

  assert property (@(posedge clk) disable iff (!i_rst_n) exp_valid |-> ev_gate == exp_gate)
    else begin
      err_count++;
      $display("ERR t=%0t o_event.gate exp=%h got=%h", $time,
               $sampled(exp_gate), $sampled(ev_gate));
    end

  assert property (@(posedge clk) disable iff (!i_rst_n) exp_valid |-> ev_mask == exp_mask)
    else begin
      err_count++;
      $display("ERR t=%0t o_event.mask exp=%h got=%h", $time,
               $sampled(exp_mask), $sampled(ev_mask));
    end

  assert property (@(posedge clk) disable iff (!i_rst_n) exp_valid |-> ev_meas == exp_meas)
    else begin
      err_count++;
      $display("ERR t=%0t o_event.measure exp=%0b got=%0b", $time,
               $sampled(exp_meas), $sampled(ev_meas));
    end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////
  function automatic qpu_pkg::qpu_instr_u cls_word(input qpu_pkg::qpu_op_e op,
      input logic [2:0] rd, input logic [2:0] rs1, input logic [15:0] imm);
    qpu_pkg::qpu_instr_u w;
    w            = '0;
    w.cls.opcode = op;
    w.cls.rd     = rd;
    w.cls.rs1    = rs1;
    w.cls.imm    = imm;
    return w;
  endfunction

  function automatic qpu_pkg::qpu_instr_u q_word(input qpu_pkg::qpu_op_e op,
      input logic [2:0] sidx, input logic [7:0] mask, input logic [7:0] gate);
    qpu_pkg::qpu_instr_u w;
    w          = '0;
    w.q.opcode = op;
    w.q.sidx   = sidx;
    w.q.mask   = mask;
    w.q.gate   = gate;
    return w;
  endfunction

  // Called 1 unit after an edge, returns 1 unit after the accepting edge
  task automatic send_instr(input qpu_pkg::qpu_instr_u w, output int waited);
    logic rdy;
    int   n;
    i_instr       = w;
    i_instr_valid = 1'b1;
    rdy           = 1'b0;
    n             = 0;
    while (!rdy && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      rdy = o_instr_ready;
      @(posedge clk);
      #1;
      if (!rdy)
      begin
        n++;
      end
    end
    i_instr_valid = 1'b0;
    i_instr       = '0;
    waited        = n;
    if (!rdy)
    begin
      $display("Timeout: instruction %h was not accepted within %0d cycles", w, WAIT_LIMIT);
      -> abort_ev;
    end
  endtask

  // One-cycle result pulse from the measurement unit
  task automatic return_result(input logic [2:0] qubit, input logic value, input int delay);
    repeat (delay) @(posedge clk);
    #1;
    i_meas = '{valid: 1'b1, qubit: qubit, value: value};
    @(posedge clk);
    #1;
    i_meas = '0;
  endtask

  task automatic end_test(input string name, input int errs_before);
    test_count++;
    $display("test %0d %s: %0d errors", test_count, name, err_count - errs_before);
  endtask

  initial
  begin
    @(abort_ev);
    $display("Errors found");
    $finish;
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial
  begin
    int waited;
    int errs;
    clk           = 1'b0;
    i_rst_n       = 1'b0;
    i_instr_valid = 1'b0;
    i_instr       = '0;
    i_meas        = '0;
    err_count     = 0;
    test_count    = 0;
    void'($urandom(32'h1fc9ac74));
    repeat (2) @(posedge clk);
    #1;
    i_rst_n = 1'b1;

    // Idle state, then a QOP at time zero
    errs = err_count;
    repeat (2) @(posedge clk);
    #1;
    send_instr(q_word(qpu_pkg::OP_QOP, 3'd0, 8'd0, 8'h5a), waited);
    end_test("reset and first event", errs);

    // ADDI chains, seen through QWAIT then QOP
    errs = err_count;
    for (int r = 0; r < 8; r++)
    begin
      send_instr(cls_word(qpu_pkg::OP_ADDI, 3'(r), 3'($urandom), 16'($urandom)), waited);
    end
    for (int r = 0; r < 8; r++)
    begin
      send_instr(cls_word(qpu_pkg::OP_QWAIT, 3'd0, 3'(r), 16'($urandom)), waited);
      send_instr(q_word(qpu_pkg::OP_QOP, 3'd0, 8'd0, 8'($urandom)), waited);
    end
    end_test("addi and qwait timing", errs);

    // Mask registers
    errs = err_count;
    for (int s = 0; s < 8; s++)
    begin
      send_instr(q_word(qpu_pkg::OP_SMIS, 3'(s), 8'($urandom), 8'd0), waited);
    end
    for (int s = 0; s < 8; s++)
    begin
      send_instr(q_word(qpu_pkg::OP_QOP, 3'(s), 8'd0, 8'($urandom)), waited);
    end
    end_test("smis and qop masks", errs);

    // Measure qubit 3, FMR stalls until its result returns
    errs = err_count;
    send_instr(q_word(qpu_pkg::OP_SMIS, 3'd1, 8'h08, 8'd0), waited);
    send_instr(q_word(qpu_pkg::OP_MEASURE, 3'd1, 8'd0, 8'hc3), waited);
    fork
      send_instr(cls_word(qpu_pkg::OP_FMR, 3'd5, 3'd0, 16'd3), waited);
      return_result(3'd3, 1'b1, 4);
    join
    if (waited == 0)
    begin
      err_count++;
      $display("FMR was accepted while its qubit still had a measurement pending");
    end
    send_instr(cls_word(qpu_pkg::OP_QWAIT, 3'd0, 3'd5, 16'd0), waited);
    send_instr(q_word(qpu_pkg::OP_QOP, 3'd0, 8'd0, 8'h11), waited);
    end_test("measure and fmr", errs);

    // Overlapping MEASURE waits, a disjoint one goes at once
    errs = err_count;
    send_instr(q_word(qpu_pkg::OP_SMIS, 3'd2, 8'h30, 8'd0), waited);
    send_instr(q_word(qpu_pkg::OP_SMIS, 3'd3, 8'h20, 8'd0), waited);
    send_instr(q_word(qpu_pkg::OP_SMIS, 3'd4, 8'h03, 8'd0), waited);
    send_instr(q_word(qpu_pkg::OP_MEASURE, 3'd2, 8'd0, 8'h21), waited);
    fork
      send_instr(q_word(qpu_pkg::OP_MEASURE, 3'd3, 8'd0, 8'h22), waited);
      return_result(3'd5, 1'b0, 3);
    join
    if (waited == 0)
    begin
      err_count++;
      $display("MEASURE on a pending qubit was accepted without waiting");
    end
    send_instr(q_word(qpu_pkg::OP_MEASURE, 3'd4, 8'd0, 8'h23), waited);
    if (waited != 0)
    begin
      err_count++;
      $display("MEASURE on free qubits was held back for %0d cycles", waited);
    end
    end_test("measure overlap", errs);

    repeat (3) @(posedge clk);
    $display("tests: %0d, errors: %0d", test_count, err_count);
    if (err_count == 0)
    begin
      $display("No errors");
    end
    else
    begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* flist.f */
qpu_pkg.sv
qpu_exu_decode.sv
qpu_exu_regfile.sv
qpu_exu_moitf.sv
qpu_exu_alu.sv
qpu_exu_top.sv
tb_qpu_exu_top.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert --top-module tb_qpu_exu_top -f flist.f -o sim_tb \
  && out=$(./obj_dir/sim_tb) \
  && echo "$out" \
  && echo "$out" | grep -q "No errors" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
